// File: include/csr_defines.svh
// CSR file constants: CSR numbers, op codes, reset values and bit positions
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// Machine CSR numbers
`define CSR_ADDR_MSTATUS        12'h300
`define CSR_ADDR_MISA           12'h301
`define CSR_ADDR_MIE            12'h304
`define CSR_ADDR_MTVEC          12'h305
`define CSR_ADDR_MCOUNTINHIBIT  12'h320
`define CSR_ADDR_MSCRATCH       12'h340
`define CSR_ADDR_MEPC           12'h341
`define CSR_ADDR_MCAUSE         12'h342
`define CSR_ADDR_MTVAL          12'h343
`define CSR_ADDR_MIP            12'h344
`define CSR_ADDR_MCYCLE         12'hB00
`define CSR_ADDR_MINSTRET       12'hB02
`define CSR_ADDR_MVENDORID      12'hF11
`define CSR_ADDR_MARCHID        12'hF12
`define CSR_ADDR_MIMPID         12'hF13
`define CSR_ADDR_MHARTID        12'hF14
`define CSR_ADDR_RO_TOP         2'b11          // addr[11:10] of a read-only CSR

// CSR instruction op codes
`define CSR_OPC_READ            2'b00
`define CSR_OPC_WRITE           2'b01
`define CSR_OPC_SET             2'b10
`define CSR_OPC_CLEAR           2'b11

// Constant reads, RV32 I, M and C
`define MISA_VALUE              32'h4000_1104
`define MVENDORID_VALUE         32'h0000_0000  // Non-commercial
`define MARCHID_VALUE           32'h0000_0021
`define MHARTID_VALUE           32'h0000_0000  // Single hart

// Software, timer and external interrupt bits
`define IRQ_MASK                32'h0000_0888

`define MSTATUS_RST_VAL         32'h0000_1800  // mpp = machine, mie clear
`define MTVEC_RST_VAL           32'h0000_0001  // Vectored mode at base 0
`define MSTATUS_MIE_BIT         3
`define MSTATUS_MPIE_BIT        7

// mcountinhibit bits
`define CNT_IDX_MCYCLE          0
`define CNT_IDX_MINSTRET        2
`define CNT_INHIBIT_RST         32'h0000_0005  // Both counters stopped

`endif

// File: project.f
+incdir+include
verilog/csr_pkg.sv
verilog/csr_read_decode.sv
verilog/csr_wb_update.sv
verilog/csr_trap_regs.sv
verilog/csr_counters.sv
verilog/csr_file.sv
tests/csr_file_assert.sv
tests/csr_file_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the CSR file testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module csr_file_tb -f project.f \
  -o csr_file_sim > build.log 2>&1 &&
  ./obj_dir/csr_file_sim > sim.log 2>&1 ||
  echo "Build or simulation run failed, see build.log and sim.log"

cat sim.log 2>/dev/null
grep -q "^No errors$" sim.log && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

// File: tests/csr_file_assert.sv
// CSR file checks: one-hot WB write strobes, kill gating and exclusive trap strobes
`timescale 1ns/100ps

module csr_file_assert import csr_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  input csr_wr_t wr_i,           // WB write bundle leaving csr_wb_update
  input logic    kill_wb_i,
  input logic    save_cause_i,
  input logic    restore_mret_i
);

  logic [8:0] strobes;  // Every write enable of the bundle

  assign strobes = {wr_i.mstatus_we, wr_i.mie_we, wr_i.mtvec_we, wr_i.mscratch_we,
                    wr_i.mepc_we, wr_i.mcause_we, wr_i.mcycle_we, wr_i.minstret_we,
                    wr_i.mcountinhibit_we};

  //////////////////////////////
  // WB strobes
  //////////////////////////////
  strobe_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(strobes))
    else $error("More than one CSR write strobe active: %b", strobes);

  // A killed WB instruction must not touch any CSR
  strobe_killed: assert property (@(posedge clk) disable iff (!rst_n)
    kill_wb_i |-> (strobes == '0))
    else $error("CSR write strobe active while kill_wb is set: %b", strobes);

  // Trap entry and MRET never in the same cycle
  trap_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(save_cause_i && restore_mret_i))
    else $error("save_cause and restore_mret both high");

endmodule

bind csr_file csr_file_assert csr_file_assert_i (
  .clk            (clk),
  .rst_n          (rst_n),
  .wr_i           (wr),
  .kill_wb_i      (trap_ctrl_i.kill_wb),
  .save_cause_i   (trap_ctrl_i.save_cause),
  .restore_mret_i (trap_ctrl_i.restore_mret)
);

// File: tests/csr_file_tb.sv
// CSR file testbench: replays one stimulus line per cycle and checks the read port
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_file_tb import csr_pkg::*; ();

  localparam int STIM_LINES     = 29;                             // Data lines in the stim file
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = STIM_LINES + RESET_CYCLES + 20;
  localparam int NUM_FIELDS     = 22;                             // Columns per data line

  logic        clk = 1'b0;
  logic        rst_n;
  ex_csr_req_t ex_req;
  wb_csr_req_t wb_req;
  trap_ctrl_t  trap_ctrl;
  csr_data_t   mip;
  csr_data_t   rdata;
  logic        illegal;
  logic        counter_read;
  csr_data_t   mie;
  csr_data_t   mepc;
  logic [23:0] mtvec_addr;
  logic [1:0]  mtvec_mode;
  logic        m_irq_enable;

  int errors = 0;
  int checks = 0;
  int cycles = 0;

  always #50 clk = ~clk;  // 100 ns period

  csr_file csr_file_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_req_i       (ex_req),
    .wb_req_i       (wb_req),
    .trap_ctrl_i    (trap_ctrl),
    .mip_i          (mip),
    .rdata_o        (rdata),
    .illegal_o      (illegal),
    .counter_read_o (counter_read),
    .mie_o          (mie),
    .mepc_o         (mepc),
    .mtvec_addr_o   (mtvec_addr),
    .mtvec_mode_o   (mtvec_mode),
    .m_irq_enable_o (m_irq_enable)
  );

  // Compare one value, report and count a mismatch
  task automatic check_value(input string name, input csr_data_t exp, input csr_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  //////////////////////////////
  // Watchdog
  //////////////////////////////
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: stimulus still running after %0d cycles", cycles);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("Errors found");
      $finish;
    end
  end

  initial begin : replay
    int        fd;
    int        rc;
    int        line_no;
    string     line;
    string     tag;
    csr_data_t fld [NUM_FIELDS];
    csr_data_t scratch_val;  // Last random mscratch value
    csr_data_t exp_rdata;
    logic      exp_cnt;
    logic      ex_live;      // Live CSR read in EX

    line_no     = 0;
    scratch_val = '0;
    rc          = $urandom(32'h4d19d176);  // Seed once
    rst_n     <= 1'b0;
    ex_req    <= '0;
    wb_req    <= '0;
    trap_ctrl <= '0;
    mip       <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);  // Trap vector still at its reset value
    check_value("reset mtvec", `MTVEC_RST_VAL, {mtvec_addr, 6'b0, mtvec_mode});

    fd = $fopen("tests/csr_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the stimulus file tests/csr_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        rc   = $fgets(line, fd);
        if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin  // Skip comments
          line_no++;
          rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                       fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15],
                       fld[16], fld[17], fld[18], fld[19], fld[20], fld[21]);
          if (rc != NUM_FIELDS) begin
            errors++;
            $display("Stimulus line %0d has %0d fields, %0d expected", line_no, rc, NUM_FIELDS);
          end else begin
            if (fld[1] == 32'd1)
              scratch_val = $urandom();                             // Fresh write value
            exp_rdata = (fld[1] == 32'd2) ? scratch_val : fld[19];
            ex_live   = fld[2][0] & fld[3][0];
            // Counter read hint for a live mcycle or minstret access
            exp_cnt = ex_live &
                      (fld[5][11:0] == `CSR_ADDR_MCYCLE || fld[5][11:0] == `CSR_ADDR_MINSTRET);

            @(posedge clk);
            ex_req.valid           <= fld[2][0];
            ex_req.csr_en          <= fld[3][0];
            ex_req.op              <= csr_op_e'(fld[4][1:0]);
            ex_req.addr            <= fld[5][11:0];
            ex_req.operand         <= {20'h0, fld[5][11:0]};       // Address rides the operand
            wb_req.valid           <= fld[6][0];
            wb_req.csr_en          <= fld[7][0];
            wb_req.op              <= csr_op_e'(fld[8][1:0]);
            wb_req.addr            <= fld[9][11:0];
            wb_req.wdata           <= (fld[1] == 32'd1) ? scratch_val : fld[10];
            wb_req.old_rdata       <= fld[11];
            trap_ctrl.kill_wb      <= fld[12][0];
            trap_ctrl.save_cause   <= fld[13][0];
            trap_ctrl.restore_mret <= fld[14][0];
            trap_ctrl.instret      <= fld[15][0];
            trap_ctrl.cause        <= mcause_t'(fld[16]);
            trap_ctrl.trap_pc      <= fld[17];
            mip                    <= fld[18];

            @(negedge clk);  // Combinational read port settled
            tag = $sformatf("behavior %0d line %0d", fld[0], line_no);
            check_value({tag, " rdata"}, exp_rdata, rdata);
            check_value({tag, " illegal"}, {31'b0, fld[20][0]}, {31'b0, illegal});
            check_value({tag, " irq enable"}, {31'b0, fld[21][0]}, {31'b0, m_irq_enable});
            check_value({tag, " counter read"}, {31'b0, exp_cnt}, {31'b0, counter_read});
            // Register outputs match the value read from the same CSR
            if (ex_live && fld[5][11:0] == `CSR_ADDR_MIE)
              check_value({tag, " mie out"}, exp_rdata, mie);
            if (ex_live && fld[5][11:0] == `CSR_ADDR_MEPC)
              check_value({tag, " mepc out"}, exp_rdata, mepc);
          end
        end
      end
      $fclose(fd);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: tests/csr_stim.txt
# tst flg | ex: v en op addr | wb: v en op addr wdata old | kill save mret iret cause pc | mip | exp: rdata ill irq
# flg 1 replaces wb wdata by a random draw, flg 2 expects the last draw as rdata; all fields hex
1 1  0 0 0 000  1 1 1 340 0 0         0 0 0 0 0 0  0    0 0 0
1 2  1 1 0 340  0 0 0 000 0 0         0 0 0 0 0 0  0    0 0 0
1 0  0 0 0 000  1 1 1 304 ffffffff 0  0 0 0 0 0 0  0    0 0 0
1 0  1 1 0 304  1 1 2 341 1001 0      0 0 0 0 0 0  0    888 0 0
1 0  1 1 0 341  1 1 3 304 8 888       0 0 0 0 0 0  0    1000 0 0
1 0  1 1 0 304  1 1 1 340 55aa00ff 0  1 0 0 0 0 0  0    880 0 0
1 2  1 1 0 340  1 1 0 340 12345678 0  0 0 0 0 0 0  0    0 0 0
1 2  1 1 0 340  1 1 2 304 8 880       0 0 0 0 0 0  0    0 0 0
1 0  1 1 0 304  0 0 0 000 0 0         0 0 0 0 0 0  0    888 0 0
2 0  1 1 0 301  0 0 0 000 0 0         0 0 0 0 0 0  0    40001104 0 0
2 0  1 1 0 f11  0 0 0 000 0 0         0 0 0 0 0 0  0    0 0 0
2 0  1 1 0 f12  0 0 0 000 0 0         0 0 0 0 0 0  0    21 0 0
2 0  1 1 0 f14  0 0 0 000 0 0         0 0 0 0 0 0  0    0 0 0
2 0  1 1 0 7c0  0 0 0 000 0 0         0 0 0 0 0 0  0    0 1 0
2 0  1 1 2 f12  0 0 0 000 0 0         0 0 0 0 0 0  0    21 1 0
2 0  1 1 0 344  0 0 0 000 0 0         0 0 0 0 0 0  888  888 0 0
3 0  0 0 0 000  1 1 1 300 8 0         0 0 0 0 0 0  0    0 0 0
3 0  1 1 0 300  0 0 0 000 0 0         0 0 0 0 0 0  0    1808 0 1
3 0  0 0 0 000  1 1 1 341 2222 0      0 1 0 0 8000000b 404  0  0 0 1
3 0  1 1 0 341  0 0 0 000 0 0         0 0 0 0 0 0  0    404 0 0
3 0  1 1 0 342  0 0 0 000 0 0         0 0 0 0 0 0  0    8000000b 0 0
4 0  1 1 0 300  0 0 0 000 0 0         0 0 1 0 0 0  0    1880 0 0
4 0  1 1 0 300  0 0 0 000 0 0         0 0 0 0 0 0  0    1888 0 1
5 0  1 1 0 b00  1 1 1 320 0 0         0 0 0 0 0 0  0    0 0 1
5 0  1 1 0 320  1 1 1 b00 100 0       0 0 0 1 0 0  0    0 0 1
5 0  1 1 0 b00  0 0 0 000 0 0         0 0 0 0 0 0  0    100 0 1
5 0  1 1 0 b00  0 0 0 000 0 0         0 0 0 1 0 0  0    101 0 1
5 0  1 1 0 b02  0 0 0 000 0 0         0 0 0 0 0 0  0    2 0 1
5 0  1 1 0 b00  0 0 0 000 0 0         0 0 0 0 0 0  0    103 0 1

// File: verilog/csr_counters.sv
// Machine counters mcycle and minstret with the mcountinhibit control
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_counters import csr_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  csr_wr_t   wr_i,
  input  logic      instret_i,
  output csr_data_t mcycle_o,
  output csr_data_t minstret_o,
  output csr_data_t mcountinhibit_o
);

  // Only the two implemented inhibit bits are kept
  localparam csr_data_t INHIBIT_MASK = (32'h1 << `CNT_IDX_MCYCLE) |
                                       (32'h1 << `CNT_IDX_MINSTRET);

  csr_data_t mcycle_q, minstret_q, mcountinhibit_q;
  logic      mcycle_inc;    // Count this edge
  logic      minstret_inc;

  assign mcycle_inc   = ~mcountinhibit_q[`CNT_IDX_MCYCLE];
  assign minstret_inc = ~mcountinhibit_q[`CNT_IDX_MINSTRET] & instret_i;

  ////////////////////////////////
  // Counters, write beats count
  ////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcycle_q        <= '0;
      minstret_q      <= '0;
      mcountinhibit_q <= `CNT_INHIBIT_RST;  // Stopped out of reset
    end else begin
      if (wr_i.mcycle_we)
        mcycle_q <= wr_i.data;
      else if (mcycle_inc)
        mcycle_q <= mcycle_q + 32'd1;       // Wraps at 2^32

      if (wr_i.minstret_we)
        minstret_q <= wr_i.data;
      else if (minstret_inc)
        minstret_q <= minstret_q + 32'd1;

      if (wr_i.mcountinhibit_we)
        mcountinhibit_q <= wr_i.data & INHIBIT_MASK;
    end
  end

  assign mcycle_o        = mcycle_q;
  assign minstret_o      = minstret_q;
  assign mcountinhibit_o = mcountinhibit_q;

endmodule

// File: verilog/csr_file.sv
// Machine-mode CSR file top: read port, WB update, trap registers and counters
`timescale 1ns/100ps

module csr_file import csr_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  ex_csr_req_t ex_req_i,
  input  wb_csr_req_t wb_req_i,
  input  trap_ctrl_t  trap_ctrl_i,
  input  csr_data_t   mip_i,
  output csr_data_t   rdata_o,
  output logic        illegal_o,
  output logic        counter_read_o,
  output csr_data_t   mie_o,
  output csr_data_t   mepc_o,
  output logic [23:0] mtvec_addr_o,
  output logic [1:0]  mtvec_mode_o,
  output logic        m_irq_enable_o
);

  csr_wr_t   wr;  // WB write bundle
  csr_data_t mstatus, mtvec, mscratch, mcause;
  csr_data_t mcycle, minstret, mcountinhibit;

  csr_read_decode csr_read_decode_i (
    .ex_req_i        (ex_req_i),
    .mstatus_i       (mstatus),
    .mie_i           (mie_o),
    .mtvec_i         (mtvec),
    .mscratch_i      (mscratch),
    .mepc_i          (mepc_o),
    .mcause_i        (mcause),
    .mip_i           (mip_i),
    .mcycle_i        (mcycle),
    .minstret_i      (minstret),
    .mcountinhibit_i (mcountinhibit),
    .rdata_o         (rdata_o),
    .illegal_o       (illegal_o),
    .counter_read_o  (counter_read_o)
  );

  csr_wb_update csr_wb_update_i (
    .wb_req_i  (wb_req_i),
    .kill_wb_i (trap_ctrl_i.kill_wb),  // Only kill drops a WB write
    .wr_o      (wr)
  );

  csr_trap_regs csr_trap_regs_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .wr_i           (wr),
    .trap_ctrl_i    (trap_ctrl_i),
    .mstatus_o      (mstatus),
    .mie_o          (mie_o),
    .mtvec_o        (mtvec),
    .mscratch_o     (mscratch),
    .mepc_o         (mepc_o),
    .mcause_o       (mcause),
    .mtvec_addr_o   (mtvec_addr_o),
    .mtvec_mode_o   (mtvec_mode_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  csr_counters csr_counters_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .wr_i            (wr),
    .instret_i       (trap_ctrl_i.instret),
    .mcycle_o        (mcycle),
    .minstret_o      (minstret),
    .mcountinhibit_o (mcountinhibit)
  );

endmodule

// File: verilog/csr_pkg.sv
// CSR file types: widths, op codes and the pipeline and controller bundles
package csr_pkg;

`include "csr_defines.svh"

  typedef logic [11:0] csr_addr_t;  // CSR number
  typedef logic [31:0] csr_data_t;  // CSR data word

  // CSR instruction flavour
  typedef enum logic [1:0] {
    CSR_OP_READ  = `CSR_OPC_READ,
    CSR_OP_WRITE = `CSR_OPC_WRITE,
    CSR_OP_SET   = `CSR_OPC_SET,
    CSR_OP_CLEAR = `CSR_OPC_CLEAR
  } csr_op_e;

  typedef struct packed {
    logic        irq;      // Interrupt, not exception
    logic [30:0] exccode;
  } mcause_t;

  ////////////////////////////////
  // Pipeline stage requests
  ////////////////////////////////
  typedef struct packed {
    logic      valid;
    logic      csr_en;
    csr_op_e   op;
    csr_addr_t addr;       // Decoded CSR number, carried on to WB
    csr_data_t operand;    // ALU operand, low 12 bits hold the read address
  } ex_csr_req_t;

  typedef struct packed {
    logic      valid;
    logic      csr_en;
    csr_op_e   op;
    csr_addr_t addr;
    csr_data_t wdata;      // rs1 or immediate
    csr_data_t old_rdata;  // Value read in EX
  } wb_csr_req_t;

  // Controller strobes
  typedef struct packed {
    logic      kill_wb;
    logic      save_cause;    // Trap entry
    logic      restore_mret;
    logic      instret;       // Instruction retired this cycle
    mcause_t   cause;
    csr_data_t trap_pc;
  } trap_ctrl_t;

  // WB write bundle, one strobe per writable CSR
  typedef struct packed {
    csr_data_t data;
    logic      mstatus_we;
    logic      mie_we;
    logic      mtvec_we;
    logic      mscratch_we;
    logic      mepc_we;
    logic      mcause_we;
    logic      mcycle_we;
    logic      minstret_we;
    logic      mcountinhibit_we;
  } csr_wr_t;

endpackage

// File: verilog/csr_read_decode.sv
// CSR read port: EX-stage read multiplexer with illegal access detection
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_read_decode import csr_pkg::*; (
  input  ex_csr_req_t ex_req_i,
  input  csr_data_t   mstatus_i,
  input  csr_data_t   mie_i,
  input  csr_data_t   mtvec_i,
  input  csr_data_t   mscratch_i,
  input  csr_data_t   mepc_i,
  input  csr_data_t   mcause_i,
  input  csr_data_t   mip_i,
  input  csr_data_t   mcycle_i,
  input  csr_data_t   minstret_i,
  input  csr_data_t   mcountinhibit_i,
  output csr_data_t   rdata_o,
  output logic        illegal_o,
  output logic        counter_read_o
);

  logic      access;    // Live CSR instruction in EX
  csr_addr_t raddr;
  logic      unknown;   // No such CSR
  logic      ro_write;  // Modify attempt on a read-only CSR

  assign access = ex_req_i.valid & ex_req_i.csr_en;
  assign raddr  = access ? ex_req_i.operand[11:0] : '0;  // Quiet mux when idle

  always_comb begin
    rdata_o        = '0;
    unknown        = 1'b0;
    counter_read_o = 1'b0;
    case (raddr)
      `CSR_ADDR_MSTATUS:       rdata_o = mstatus_i;
      `CSR_ADDR_MISA:          rdata_o = `MISA_VALUE;
      `CSR_ADDR_MIE:           rdata_o = mie_i;
      `CSR_ADDR_MTVEC:         rdata_o = mtvec_i;
      `CSR_ADDR_MCOUNTINHIBIT: rdata_o = mcountinhibit_i;
      `CSR_ADDR_MSCRATCH:      rdata_o = mscratch_i;
      `CSR_ADDR_MEPC:          rdata_o = mepc_i;
      `CSR_ADDR_MCAUSE:        rdata_o = mcause_i;
      `CSR_ADDR_MIP:           rdata_o = mip_i;
      `CSR_ADDR_MVENDORID:     rdata_o = `MVENDORID_VALUE;
      `CSR_ADDR_MARCHID:       rdata_o = `MARCHID_VALUE;
      `CSR_ADDR_MHARTID:       rdata_o = `MHARTID_VALUE;
      `CSR_ADDR_MIMPID,
      `CSR_ADDR_MTVAL:         rdata_o = '0;          // Implemented as zero
      `CSR_ADDR_MCYCLE: begin
        rdata_o        = mcycle_i;
        counter_read_o = 1'b1;                        // Controller bypass hint
      end
      `CSR_ADDR_MINSTRET: begin
        rdata_o        = minstret_i;
        counter_read_o = 1'b1;
      end
      default:                 unknown = 1'b1;        // Address 0 lands here when idle
    endcase
  end

  // Read-only space is addr[11:10] == 2'b11
  assign ro_write  = (ex_req_i.op != CSR_OP_READ) && (raddr[11:10] == `CSR_ADDR_RO_TOP);
  assign illegal_o = access & (unknown | ro_write);

endmodule

// File: verilog/csr_trap_regs.sv
// Machine trap CSRs with software writes, trap entry and MRET return
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_trap_regs import csr_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  csr_wr_t     wr_i,
  input  trap_ctrl_t  trap_ctrl_i,
  output csr_data_t   mstatus_o,
  output csr_data_t   mie_o,
  output csr_data_t   mtvec_o,
  output csr_data_t   mscratch_o,
  output csr_data_t   mepc_o,
  output csr_data_t   mcause_o,
  output logic [23:0] mtvec_addr_o,
  output logic [1:0]  mtvec_mode_o,
  output logic        m_irq_enable_o
);

  csr_data_t mstatus_q, mie_q, mtvec_q, mscratch_q, mepc_q, mcause_q;
  csr_data_t mstatus_n, mepc_n, mcause_n;
  logic      mstatus_we, mepc_we, mcause_we;

  ////////////////////////////////
  // Next state, controller wins
  ////////////////////////////////
  always_comb begin
    mstatus_n                    = `MSTATUS_RST_VAL;  // mpp stays machine
    mstatus_n[`MSTATUS_MIE_BIT]  = wr_i.data[`MSTATUS_MIE_BIT];
    mstatus_n[`MSTATUS_MPIE_BIT] = wr_i.data[`MSTATUS_MPIE_BIT];
    mstatus_we                   = wr_i.mstatus_we;
    mepc_n                       = wr_i.data & ~32'h1;  // Halfword aligned
    mepc_we                      = wr_i.mepc_we;
    mcause_n                     = wr_i.data;
    mcause_we                    = wr_i.mcause_we;

    if (trap_ctrl_i.save_cause) begin
      mstatus_n                    = mstatus_q;
      mstatus_n[`MSTATUS_MPIE_BIT] = mstatus_q[`MSTATUS_MIE_BIT];  // Push enable
      mstatus_n[`MSTATUS_MIE_BIT]  = 1'b0;
      mstatus_we                   = 1'b1;
      mepc_n                       = trap_ctrl_i.trap_pc;
      mepc_we                      = 1'b1;
      mcause_n                     = trap_ctrl_i.cause;
      mcause_we                    = 1'b1;
    end else if (trap_ctrl_i.restore_mret) begin
      mstatus_n                    = mstatus_q;
      mstatus_n[`MSTATUS_MIE_BIT]  = mstatus_q[`MSTATUS_MPIE_BIT];  // Pop enable
      mstatus_n[`MSTATUS_MPIE_BIT] = 1'b1;
      mstatus_we                   = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q  <= `MSTATUS_RST_VAL;
      mie_q      <= '0;
      mtvec_q    <= `MTVEC_RST_VAL;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else begin
      if (mstatus_we)       mstatus_q  <= mstatus_n;
      if (wr_i.mie_we)      mie_q      <= wr_i.data & `IRQ_MASK;
      // Base address plus mode bit 0, rest reads zero
      if (wr_i.mtvec_we)    mtvec_q    <= {wr_i.data[31:8], 7'b0, wr_i.data[0]};
      if (wr_i.mscratch_we) mscratch_q <= wr_i.data;
      if (mepc_we)          mepc_q     <= mepc_n;
      if (mcause_we)        mcause_q   <= mcause_n;
    end
  end

  assign mstatus_o      = mstatus_q;
  assign mie_o          = mie_q;
  assign mtvec_o        = mtvec_q;
  assign mscratch_o     = mscratch_q;
  assign mepc_o         = mepc_q;
  assign mcause_o       = mcause_q;
  assign mtvec_addr_o   = mtvec_q[31:8];
  assign mtvec_mode_o   = mtvec_q[1:0];
  assign m_irq_enable_o = mstatus_q[`MSTATUS_MIE_BIT];  // Global interrupt enable

endmodule

// File: verilog/csr_wb_update.sv
// CSR write port: WB-stage read-modify-write data and per-register strobes
`timescale 1ns/100ps
`include "csr_defines.svh"

module csr_wb_update import csr_pkg::*; (
  input  wb_csr_req_t wb_req_i,
  input  logic        kill_wb_i,
  output csr_wr_t     wr_o
);

  logic live;  // Request actually modifies a CSR

  assign live = wb_req_i.valid & wb_req_i.csr_en & ~kill_wb_i &
                (wb_req_i.op != CSR_OP_READ);

  always_comb begin
    wr_o = '0;

    ////////////////////////////////
    // Merge with the EX read value
    ////////////////////////////////
    case (wb_req_i.op)
      CSR_OP_SET:   wr_o.data = wb_req_i.wdata | wb_req_i.old_rdata;
      CSR_OP_CLEAR: wr_o.data = ~wb_req_i.wdata & wb_req_i.old_rdata;
      default:      wr_o.data = wb_req_i.wdata;    // WRITE, READ carries no strobe
    endcase

    // One-hot strobe on the WB address
    if (live) begin
      case (wb_req_i.addr)
        `CSR_ADDR_MSTATUS:       wr_o.mstatus_we       = 1'b1;
        `CSR_ADDR_MIE:           wr_o.mie_we           = 1'b1;
        `CSR_ADDR_MTVEC:         wr_o.mtvec_we         = 1'b1;
        `CSR_ADDR_MSCRATCH:      wr_o.mscratch_we      = 1'b1;
        `CSR_ADDR_MEPC:          wr_o.mepc_we          = 1'b1;
        `CSR_ADDR_MCAUSE:        wr_o.mcause_we        = 1'b1;
        `CSR_ADDR_MCYCLE:        wr_o.mcycle_we        = 1'b1;
        `CSR_ADDR_MINSTRET:      wr_o.minstret_we      = 1'b1;
        `CSR_ADDR_MCOUNTINHIBIT: wr_o.mcountinhibit_we = 1'b1;
        default: ;                                    // misa, mip, mtval ignore writes
      endcase
    end
  end

endmodule
